/* include/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// word sizes on the requester side
`define MEM_DATA_W 16
`define MEM_ADDR_W 16

// on-chip startup ram depth
// also the first external word address
`define MEM_INT_WORDS 200

// external async sram address pins
`define MEM_EXT_ADDR_W 16

`endif

/* hw/mem_pkg.sv */
`include "mem_config.svh"

package mem_pkg;

  typedef logic [`MEM_DATA_W-1:0] data_t;  // one data word
  typedef logic [`MEM_ADDR_W-1:0] addr_t;  // requester word address

  // owner of the access in flight
  typedef enum logic {
    TGT_INT = 1'b0,  // startup ram
    TGT_EXT = 1'b1   // external sram
  } target_t;

  // states of the external sram controller
  typedef enum logic [2:0] {
    EXT_IDLE    = 3'd0,
    EXT_RD_ADDR = 3'd1,  // read set address
    EXT_RD_GET  = 3'd2,  // read data get
    EXT_RD_FIN  = 3'd3,  // read finish
    EXT_WR_ADDR = 3'd4,  // write set address
    EXT_WR_WE   = 3'd5,  // write set we
    EXT_WR_FIN  = 3'd6   // write finish
  } ext_state_t;

endpackage

/* hw/startup_ram.sv */
`timescale 1ns/100ps
`include "mem_config.svh"

// on-chip startup ram, one access per four-phase handshake
module startup_ram import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,    // request level from the router
  input  logic  we,     // 1 write, 0 read
  input  addr_t addr,
  input  data_t wdata,
  output logic  ack,
  output data_t rdata
);

  localparam int IDX_W = $clog2(`MEM_INT_WORDS);

  data_t             mem [`MEM_INT_WORDS];
  logic  [IDX_W-1:0] idx;
  logic              start;  // edge that raises ack

  // router only sends addresses below the boundary
  assign idx   = addr[IDX_W-1:0];
  assign start = req && !ack;

  // handshake control
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else if (start) begin
      ack <= 1'b1;            // access done in this edge
    end else if (!req) begin
      ack <= 1'b0;            // requester released
    end
  end

  // array and read data, no reset
  always_ff @(posedge clk) begin
    if (start) begin
      if (we) begin
        mem[idx] <= wdata;
      end else begin
        rdata <= mem[idx];    // valid while ack high
      end
    end
  end

endmodule

/* hw/ext_sram_ctrl.sv */
`timescale 1ns/100ps
`include "mem_config.svh"

// sequencer for an external asynchronous sram
// read:  idle -> set address -> data get -> finish
// write: idle -> set address -> set we -> finish
module ext_sram_ctrl import mem_pkg::*; (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  input  logic                       we,
  input  addr_t                      addr,
  input  data_t                      wdata,
  input  data_t                      sram_rdata,
  output logic                       ack,
  output data_t                      rdata,
  output logic [`MEM_EXT_ADDR_W-1:0] sram_addr,
  output data_t                      sram_wdata,
  output logic                       sram_data_oe,  // drive wdata onto the sram bus
  output logic                       sram_ce_n,
  output logic                       sram_oe_n,
  output logic                       sram_we_n
);

  localparam addr_t BOUND = addr_t'(`MEM_INT_WORDS);

  ext_state_t state;
  addr_t      ext_addr;  // address seen by the sram

  // rebase, external word 0 sits at the boundary
  assign ext_addr = addr - BOUND;

  // bus driven for the whole write sequence, never on reads
  assign sram_data_oe = (state == EXT_WR_ADDR) ||
                        (state == EXT_WR_WE)   ||
                        (state == EXT_WR_FIN);

  // state, strobes and ack
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= EXT_IDLE;
      ack       <= 1'b0;
      sram_ce_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_we_n <= 1'b1;
    end else begin
      case (state)
        EXT_IDLE: begin
          ack <= 1'b0;
          if (req) begin
            state <= we ? EXT_WR_ADDR : EXT_RD_ADDR;
          end
        end

        // read path
        EXT_RD_ADDR: begin
          sram_ce_n <= 1'b0;     // address goes out in the same edge
          sram_oe_n <= 1'b0;
          state     <= EXT_RD_GET;
        end
        EXT_RD_GET: begin
          sram_ce_n <= 1'b1;     // data taken, release the chip
          sram_oe_n <= 1'b1;
          ack       <= 1'b1;
          state     <= EXT_RD_FIN;
        end
        EXT_RD_FIN: begin
          if (!req) begin        // hold ack until request drops
            ack   <= 1'b0;
            state <= EXT_IDLE;
          end
        end

        // write path
        EXT_WR_ADDR: begin
          sram_ce_n <= 1'b0;     // with address and data
          state     <= EXT_WR_WE;
        end
        EXT_WR_WE: begin
          sram_we_n <= 1'b0;
          state     <= EXT_WR_FIN;
        end
        EXT_WR_FIN: begin
          if (!ack) begin
            // first edge here ends the write pulse
            sram_we_n <= 1'b1;
            sram_ce_n <= 1'b1;
            ack       <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= EXT_IDLE;
          end
        end

        default: begin
          state <= EXT_IDLE;     // unused code 7
        end
      endcase
    end
  end

  // address, write data and captured read data, no reset
  always_ff @(posedge clk) begin
    if (state == EXT_RD_ADDR || state == EXT_WR_ADDR) begin
      sram_addr <= ext_addr[`MEM_EXT_ADDR_W-1:0];
    end
    if (state == EXT_WR_ADDR) begin
      sram_wdata <= wdata;
    end
    if (state == EXT_RD_GET) begin
      rdata <= sram_rdata;       // oe low for a full cycle by now
    end
  end

endmodule

/* hw/mem_router.sv */
`timescale 1ns/100ps
`include "mem_config.svh"

// routes each request to the startup ram or the external sram by address
// no added latency, decode is combinational while idle
module mem_router import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  rd_req,
  input  logic  wr_req,
  input  addr_t addr,
  input  logic  int_ack,
  input  data_t int_rdata,
  input  logic  ext_ack,
  input  data_t ext_rdata,
  output logic  ack,
  output data_t rdata,
  output logic  int_req,
  output logic  int_we,
  output logic  ext_req,
  output logic  ext_we
);

  localparam addr_t BOUND = addr_t'(`MEM_INT_WORDS);

  logic    req_any;
  logic    busy;     // handshake in flight
  target_t sel_q;    // latched owner
  target_t dec;      // owner from the current address
  target_t tgt;      // owner used for forwarding

  assign req_any = rd_req || wr_req;
  assign dec     = (addr >= BOUND) ? TGT_EXT : TGT_INT;  // the only boundary compare
  assign tgt     = busy ? sel_q : dec;

  // latch owner when a request rises in idle
  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      sel_q <= TGT_INT;
    end else if (!busy) begin
      if (req_any) begin
        busy  <= 1'b1;
        sel_q <= dec;
      end
    end else if (!req_any) begin
      // target drops its ack in this same edge
      busy <= 1'b0;
    end
  end

  // forward the request level to one target only
  assign int_req = req_any && (tgt == TGT_INT);
  assign int_we  = wr_req  && (tgt == TGT_INT);
  assign ext_req = req_any && (tgt == TGT_EXT);
  assign ext_we  = wr_req  && (tgt == TGT_EXT);

  // return path from the owner
  assign ack   = (tgt == TGT_EXT) ? ext_ack   : int_ack;
  assign rdata = (tgt == TGT_EXT) ? ext_rdata : int_rdata;

endmodule

/* hw/mem_subsystem.sv */
`timescale 1ns/100ps
`include "mem_config.svh"

// memory subsystem top, one requester, startup ram plus external sram
module mem_subsystem import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // requester side, four-phase
  input  logic  rd_req,
  input  logic  wr_req,
  input  addr_t addr,
  input  data_t wdata,
  output logic  ack,
  output data_t rdata,
  // external sram pins
  output addr_t sram_addr,
  output data_t sram_wdata,
  input  data_t sram_rdata,
  output logic  sram_data_oe,
  output logic  sram_ce_n,
  output logic  sram_oe_n,
  output logic  sram_we_n
);

  // router to startup ram
  logic  int_req;
  logic  int_we;
  logic  int_ack;
  data_t int_rdata;

  // router to sram controller
  logic  ext_req;
  logic  ext_we;
  logic  ext_ack;
  data_t ext_rdata;

  mem_router i_mem_router (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .wr_req    (wr_req),
    .addr      (addr),
    .int_ack   (int_ack),
    .int_rdata (int_rdata),
    .ext_ack   (ext_ack),
    .ext_rdata (ext_rdata),
    .ack       (ack),
    .rdata     (rdata),
    .int_req   (int_req),
    .int_we    (int_we),
    .ext_req   (ext_req),
    .ext_we    (ext_we)
  );

  startup_ram i_startup_ram (
    .clk   (clk),
    .rst   (rst),
    .req   (int_req),
    .we    (int_we),
    .addr  (addr),
    .wdata (wdata),
    .ack   (int_ack),
    .rdata (int_rdata)
  );

  ext_sram_ctrl i_ext_sram_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (ext_req),
    .we           (ext_we),
    .addr         (addr),
    .wdata        (wdata),
    .sram_rdata   (sram_rdata),
    .ack          (ext_ack),
    .rdata        (ext_rdata),
    .sram_addr    (sram_addr),   // same width as addr_t
    .sram_wdata   (sram_wdata),
    .sram_data_oe (sram_data_oe),
    .sram_ce_n    (sram_ce_n),
    .sram_oe_n    (sram_oe_n),
    .sram_we_n    (sram_we_n)
  );

endmodule

/* tb/sram_model.sv */
`timescale 1ns/100ps
`include "mem_config.svh"

// behavioral async sram hanging on the controller pins
module sram_model import mem_pkg::*; (
  input  addr_t sram_addr,
  input  data_t sram_wdata,
  output data_t sram_rdata,
  input  logic  sram_data_oe,  // controller drives the bus
  input  logic  sram_ce_n,
  input  logic  sram_oe_n,
  input  logic  sram_we_n
);

  localparam int DEPTH = 1 << `MEM_EXT_ADDR_W;  // 64K words

  data_t mem [DEPTH];

  // power-up contents, pattern over the full address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = data_t'(i) ^ data_t'(16'hc35a);
    end
  end

  // word taken when we falls
  // address and data settled one cycle before
  always @(negedge sram_we_n) begin
    if (!sram_ce_n && sram_data_oe) begin
      mem[sram_addr] = sram_wdata;
    end
  end

  // combinational read while chip and outputs enabled
  assign sram_rdata = (!sram_ce_n && !sram_oe_n) ? mem[sram_addr] : '0;

endmodule

/* tb/mem_properties.sv */
`timescale 1ns/100ps

// handshake and strobe checks on the subsystem ports
module mem_properties (
  input logic clk,
  input logic rst,
  input logic rd_req,
  input logic wr_req,
  input logic ack,
  input logic sram_data_oe,
  input logic sram_ce_n,
  input logic sram_oe_n,
  input logic sram_we_n
);

  // ack only rises for a request the target already saw
  ack_needs_req: assert property (
    @(posedge clk) disable iff (rst) $rose(ack) |-> $past(rd_req || wr_req))
    else $error("ack rose with no request pending");

  // write pulse only inside an enabled cycle with the bus driven
  we_inside_write: assert property (
    @(posedge clk) disable iff (rst) !sram_we_n |-> (!sram_ce_n && sram_data_oe))
    else $error("sram_we_n low outside an enabled, driven write cycle");

  // read and write strobes never together
  oe_we_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(!sram_oe_n && !sram_we_n))
    else $error("sram_oe_n and sram_we_n low at the same time");

endmodule

bind mem_subsystem mem_properties i_mem_properties (
  .clk          (clk),
  .rst          (rst),
  .rd_req       (rd_req),
  .wr_req       (wr_req),
  .ack          (ack),
  .sram_data_oe (sram_data_oe),
  .sram_ce_n    (sram_ce_n),
  .sram_oe_n    (sram_oe_n),
  .sram_we_n    (sram_we_n)
);

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/100ps
`include "mem_config.svh"

// directed testbench, takes the requester's place
module tb_mem_subsystem import mem_pkg::*; ();

  localparam int CLK_HALF   = 4;     // 8 ns period
  localparam int RST_CYCLES = 16;
  localparam int SEED       = 22;
  localparam int INT_WORDS  = `MEM_INT_WORDS;
  localparam int N_DIRECTED = 20;    // accesses in the directed tasks
  localparam int N_RANDOM   = 200;
  localparam int ACK_LIMIT  = 16;    // cycles allowed for one ack
  localparam int HOLD       = 10;    // extra cycles with request held
  localparam int TIMEOUT_NS = ((N_DIRECTED + N_RANDOM) * 20 + RST_CYCLES) * 2 * CLK_HALF;
  localparam addr_t BOUND   = addr_t'(INT_WORDS);

  logic  clk    = 1'b0;
  logic  rst    = 1'b1;
  logic  rd_req = 1'b0;
  logic  wr_req = 1'b0;
  addr_t addr   = '0;
  data_t wdata  = '0;
  logic  ack;
  data_t rdata;
  addr_t sram_addr;
  data_t sram_wdata;
  data_t sram_rdata;
  logic  sram_data_oe;
  logic  sram_ce_n;
  logic  sram_oe_n;
  logic  sram_we_n;

  data_t ref_mem   [1 << `MEM_ADDR_W];  // expected contents, full space
  bit    ref_valid [1 << `MEM_ADDR_W];
  addr_t written_q [$];                  // addresses with known data
  int    val_errors   = 0;
  int    other_errors = 0;

  always #CLK_HALF clk = ~clk;

  mem_subsystem i_mem_subsystem (
    .clk          (clk),
    .rst          (rst),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .addr         (addr),
    .wdata        (wdata),
    .ack          (ack),
    .rdata        (rdata),
    .sram_addr    (sram_addr),
    .sram_wdata   (sram_wdata),
    .sram_rdata   (sram_rdata),
    .sram_data_oe (sram_data_oe),
    .sram_ce_n    (sram_ce_n),
    .sram_oe_n    (sram_oe_n),
    .sram_we_n    (sram_we_n)
  );

  sram_model i_sram_model (
    .sram_addr    (sram_addr),
    .sram_wdata   (sram_wdata),
    .sram_rdata   (sram_rdata),
    .sram_data_oe (sram_data_oe),
    .sram_ce_n    (sram_ce_n),
    .sram_oe_n    (sram_oe_n),
    .sram_we_n    (sram_we_n)
  );

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected 0x%h got 0x%h", name, exp, act);
      val_errors++;
    end
  endtask

  // one four-phase access, outputs sampled on the rising edge
  task automatic bus_access(input bit is_wr, input addr_t a, input data_t d, input int hold,
                            output data_t rd);
    int n;
    int exp_lat;
    bit got;
    bit ce_seen;
    n       = 0;
    got     = 1'b0;
    ce_seen = 1'b0;
    exp_lat = (a < BOUND) ? 1 : (is_wr ? 4 : 3);  // edges from first sample to ack
    @(posedge clk);
    rd_req <= !is_wr;
    wr_req <= is_wr;
    addr   <= a;
    wdata  <= d;
    while (!got && n < ACK_LIMIT) begin
      @(posedge clk);
      n++;
      ce_seen = ce_seen || !sram_ce_n;
      got     = ack;
    end
    rd = rdata;  // valid while ack high
    if (!got) begin
      $display("ERROR: no ack for %s at 0x%h within %0d cycles",
               is_wr ? "write" : "read", a, ACK_LIMIT);
      other_errors++;
    end else begin
      check("ack latency", 32'(exp_lat), 32'(n - 1));
    end
    check("sram_ce_n active", 32'(a >= BOUND), 32'(ce_seen));  // only external touches sram
    repeat (hold) begin
      @(posedge clk);
      check("ack held", 32'h1, 32'(ack));
      check("sram_ce_n held", 32'h1, 32'(sram_ce_n));
      check("sram_oe_n held", 32'h1, 32'(sram_oe_n));
      check("sram_we_n held", 32'h1, 32'(sram_we_n));
    end
    rd_req <= 1'b0;
    wr_req <= 1'b0;
    repeat (2) @(posedge clk);  // first edge sees the drop
    check("ack released", 32'h0, 32'(ack));
  endtask

  task automatic write_word(input addr_t a, input data_t d, input int hold);
    data_t rd_unused;
    addr_t ext_a;
    bus_access(1'b1, a, d, hold, rd_unused);
    ref_mem[a] = d;
    if (!ref_valid[a]) begin
      written_q.push_back(a);
    end
    ref_valid[a] = 1'b1;
    if (a >= BOUND) begin
      ext_a = a - BOUND;  // sram word behind this address
      check($sformatf("sram word 0x%h", ext_a), 32'(d), 32'(i_sram_model.mem[ext_a]));
    end
  endtask

  task automatic read_and_compare(input addr_t a, input int hold);
    data_t rd;
    bus_access(1'b0, a, '0, hold, rd);
    if (ref_valid[a]) begin
      check($sformatf("rdata at 0x%h", a), 32'(ref_mem[a]), 32'(rd));
    end else begin
      $display("ERROR: read of 0x%h has no expected value", a);
      other_errors++;
    end
  endtask

  task automatic after_reset_idle();
    @(posedge clk);
    check("ack", 32'h0, 32'(ack));
    check("sram_data_oe", 32'h0, 32'(sram_data_oe));
    check("sram_ce_n", 32'h1, 32'(sram_ce_n));
    check("sram_oe_n", 32'h1, 32'(sram_oe_n));
    check("sram_we_n", 32'h1, 32'(sram_we_n));
  endtask

  task automatic internal_words();
    write_word(16'd0, 16'h1111, 0);
    write_word(16'd57, 16'h5757, 0);
    write_word(16'd199, 16'hc7c7, 0);  // last internal word
    read_and_compare(16'd0, 0);
    read_and_compare(16'd57, 0);
    read_and_compare(16'd199, 0);
  endtask

  task automatic external_words();
    write_word(16'd200, 16'ha0a0, 0);  // sram word 0
    write_word(16'd201, 16'ha1a1, 0);
    write_word(16'hffff, 16'hfefe, 0);  // top of the space
    read_and_compare(16'd200, 0);
    read_and_compare(16'd201, 0);
    read_and_compare(16'hffff, 0);
  endtask

  // 199 and 200 sit on opposite sides
  task automatic boundary_split();
    write_word(16'd199, 16'h0199, 0);
    write_word(16'd200, 16'h0200, 0);
    read_and_compare(16'd199, 0);
    read_and_compare(16'd200, 0);
  endtask

  task automatic held_handshake();
    write_word(16'd42, 16'h4242, HOLD);
    write_word(16'd300, 16'h0300, HOLD);
    read_and_compare(16'd42, HOLD);
    read_and_compare(16'd300, HOLD);  // ack three edges after first sample
  endtask

  task automatic random_mix();
    addr_t a;
    bit    do_wr;
    for (int i = 0; i < N_RANDOM; i++) begin
      do_wr = ($urandom_range(1, 0) == 1) || (written_q.size() == 0);
      if (do_wr) begin
        if ($urandom_range(3, 0) == 0) begin
          a = addr_t'($urandom_range(INT_WORDS - 1, 0));  // bias toward the small ram
        end else begin
          a = addr_t'($urandom_range(16'hffff, INT_WORDS));
        end
        write_word(a, data_t'($urandom), 0);
      end else begin
        a = written_q[$urandom_range(written_q.size() - 1, 0)];
        read_and_compare(a, 0);
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    after_reset_idle();
    internal_words();
    external_words();
    boundary_split();
    held_handshake();
    random_mix();
    @(posedge clk);
    $display("closing: %0d value mismatches, %0d other errors", val_errors, other_errors);
    if (val_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // bound on total run time
  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hw/mem_pkg.sv
hw/startup_ram.sv
hw/ext_sram_ctrl.sv
hw/mem_router.sv
hw/mem_subsystem.sv
tb/sram_model.sv
tb/mem_properties.sv
tb/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module tb_mem_subsystem; then
  echo "verilator build failed"
  exit 1
fi

if ! out=$(./obj_dir/Vtb_mem_subsystem); then
  echo "$out"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
